// ==== verilog/csi_gate_config.svh ====
`ifndef CSI_GATE_CONFIG_SVH
`define CSI_GATE_CONFIG_SVH

// Flops per asynchronous input
`define CSI_SYNC_STAGES 2
// Equal samples needed before a Hall code counts
`define CSI_FILTER_CYCLES 4
// Both switches on for this many clocks
`define CSI_OVERLAP_CYCLES 10
`define CSI_OVL_CNT_W 8

`endif

// ==== verilog/csi_gate_pkg.sv ====
package csi_gate_pkg;

    // ------------------------------
    // Vector types
    // ------------------------------

    // Hall sensors, order H3 H2 H1
    typedef logic [2:0] hall_code_t;

    // One switch group, one bit per phase, order C B A
    typedef logic [2:0] phase_gates_t;

    // One-hot phase selections within a group
    localparam phase_gates_t PHASE_A = 3'b001;
    localparam phase_gates_t PHASE_B = 3'b010;
    localparam phase_gates_t PHASE_C = 3'b100;

    // Full gate vector, top group in bits 5..3
    typedef struct packed {
        phase_gates_t top;
        phase_gates_t bot;
    } gate_pattern_t;

    // Per-group overlap FSM
    typedef enum logic {OVL_IDLE = 1'b0, OVL_HOLD = 1'b1} overlap_state_t;

endpackage

// ==== verilog/hall_input_filter.sv ====
`timescale 1ns/10ps
`include "csi_gate_config.svh"

module hall_input_filter (
    input  logic                     clk,
    input  logic                     rst,
    input  csi_gate_pkg::hall_code_t hall,
    input  logic                     enable,
    output csi_gate_pkg::hall_code_t hall_accepted,
    output logic                     hall_invalid,
    output logic                     enable_sync
);
    import csi_gate_pkg::*;

    localparam int SYNC_STAGES   = `CSI_SYNC_STAGES;
    localparam int FILTER_CYCLES = `CSI_FILTER_CYCLES;
    localparam int FILT_W        = $clog2(FILTER_CYCLES + 1);

    hall_code_t             hall_sync_q [SYNC_STAGES];
    logic [SYNC_STAGES-1:0] en_sync_q;
    hall_code_t             hall_s;
    // Code currently being timed and its run length
    hall_code_t             cand_q;
    logic [FILT_W-1:0]      stable_cnt_q;

    // ------------------------------
    // Synchronizers
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                hall_sync_q[i] <= '0;
            end
            en_sync_q <= '0;
        end else begin
            hall_sync_q[0] <= hall;
            en_sync_q[0]   <= enable;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                hall_sync_q[i] <= hall_sync_q[i-1];
                en_sync_q[i]   <= en_sync_q[i-1];
            end
        end
    end

    assign hall_s      = hall_sync_q[SYNC_STAGES-1];
    assign enable_sync = en_sync_q[SYNC_STAGES-1];

    // ------------------------------
    // Stability filter
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand_q        <= '0;
            stable_cnt_q  <= '0;
            hall_accepted <= '0;
        end else if (hall_s != cand_q) begin
            // New code seen, restart the run at one sample
            cand_q       <= hall_s;
            stable_cnt_q <= FILT_W'(1);
        end else if (stable_cnt_q != FILT_W'(FILTER_CYCLES)) begin
            stable_cnt_q <= stable_cnt_q + 1'b1;
            // Last sample of the run, accept
            if (stable_cnt_q == FILT_W'(FILTER_CYCLES - 1)) begin
                hall_accepted <= cand_q;
            end
        end
    end

    // All-zero and all-one codes are sensor faults
    assign hall_invalid = (hall_accepted == 3'b000) || (hall_accepted == 3'b111);

endmodule

// ==== verilog/commutation_table.sv ====
`timescale 1ns/10ps

module commutation_table (
    input  logic                        clk,
    input  logic                        rst,
    input  csi_gate_pkg::hall_code_t    hall_accepted,
    input  logic                        hall_invalid,
    input  logic                        dir,
    output csi_gate_pkg::gate_pattern_t pattern_raw
);
    import csi_gate_pkg::*;

    phase_gates_t  fwd_top;
    phase_gates_t  fwd_bot;
    gate_pattern_t pattern_next;

    // Forward six-step table, one-hot per group
    always_comb begin
        case (hall_accepted)
            3'b101:  begin fwd_top = PHASE_A; fwd_bot = PHASE_B; end
            3'b100:  begin fwd_top = PHASE_A; fwd_bot = PHASE_C; end
            3'b110:  begin fwd_top = PHASE_B; fwd_bot = PHASE_C; end
            3'b010:  begin fwd_top = PHASE_B; fwd_bot = PHASE_A; end
            3'b011:  begin fwd_top = PHASE_C; fwd_bot = PHASE_A; end
            3'b001:  begin fwd_top = PHASE_C; fwd_bot = PHASE_B; end
            // Invalid codes never reach the register
            default: begin fwd_top = '0;      fwd_bot = '0;      end
        endcase
    end

    // Reverse runs the current the other way round
    always_comb begin
        if (dir) begin
            pattern_next.top = fwd_top;
            pattern_next.bot = fwd_bot;
        end else begin
            pattern_next.top = fwd_bot;
            pattern_next.bot = fwd_top;
        end
    end

    // Keep the last good pattern on a bad code
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern_raw <= '0;
        end else if (!hall_invalid) begin
            pattern_raw <= pattern_next;
        end
    end

endmodule

// ==== verilog/commutation_overlap.sv ====
`timescale 1ns/10ps
`include "csi_gate_config.svh"

module commutation_overlap #(
    parameter int OVERLAP_CYCLES = `CSI_OVERLAP_CYCLES
) (
    input  logic                        clk,
    input  logic                        rst,
    input  csi_gate_pkg::gate_pattern_t pattern_raw,
    output csi_gate_pkg::gate_pattern_t pattern_ovl
);
    import csi_gate_pkg::*;

    localparam int CNT_W = `CSI_OVL_CNT_W;
    // Entry cycle already shows the union, so load one less
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(OVERLAP_CYCLES - 1);

    // Index 0 is the top group, index 1 the bottom group
    phase_gates_t grp_in  [2];
    phase_gates_t grp_out [2];

    assign grp_in[0] = pattern_raw.top;
    assign grp_in[1] = pattern_raw.bot;

    // ------------------------------
    // Per-group overlap FSM
    // ------------------------------
    for (genvar g = 0; g < 2; g++) begin : g_group
        overlap_state_t   state_q;
        phase_gates_t     prev_q;
        phase_gates_t     out_q;
        logic [CNT_W-1:0] cnt_q;
        logic             turn_on;
        logic             turn_off;

        // A switch coming on and another going off in the same step
        assign turn_on  = |(~prev_q & grp_in[g]);
        assign turn_off = |(prev_q & ~grp_in[g]);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                state_q <= OVL_IDLE;
                prev_q  <= '0;
                out_q   <= '0;
                cnt_q   <= '0;
            end else begin
                // Input from the previous cycle, for edge detection
                prev_q <= grp_in[g];

                case (state_q)
                    OVL_IDLE: begin
                        if (turn_on && turn_off) begin
                            // Hand-over inside the group, both switches on
                            state_q <= OVL_HOLD;
                            out_q   <= prev_q | grp_in[g];
                            cnt_q   <= CNT_LOAD;
                        end else begin
                            out_q <= grp_in[g];
                        end
                    end

                    OVL_HOLD: begin
                        // out_q keeps the union while counting down
                        if (cnt_q != '0) begin
                            cnt_q <= cnt_q - 1'b1;
                        end else begin
                            state_q <= OVL_IDLE;
                            out_q   <= grp_in[g];
                        end
                    end

                    default: begin
                        state_q <= OVL_IDLE;
                        out_q   <= grp_in[g];
                    end
                endcase
            end
        end

        assign grp_out[g] = out_q;
    end

    // ------------------------------
    // Reassemble the gate vector
    // ------------------------------
    assign pattern_ovl.top = grp_out[0];
    assign pattern_ovl.bot = grp_out[1];

endmodule

// ==== verilog/gate_output_stage.sv ====
`timescale 1ns/10ps

module gate_output_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  csi_gate_pkg::gate_pattern_t pattern_ovl,
    input  logic                        enable_sync,
    input  logic                        hall_invalid,
    input  logic                        fault_clr,
    output csi_gate_pkg::gate_pattern_t gates,
    output logic                        fault
);
    import csi_gate_pkg::*;

    // Phase A top and bottom on, keeps the DC-link current flowing
    localparam gate_pattern_t BYPASS_PATTERN = '{top: PHASE_A, bot: PHASE_A};

    logic bypass;

    // ------------------------------
    // Fault latch
    // ------------------------------
    // Bad code wins over a clear request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fault <= 1'b0;
        end else if (hall_invalid) begin
            fault <= 1'b1;
        end else if (fault_clr) begin
            fault <= 1'b0;
        end
    end

    assign bypass = !enable_sync || fault;

    // ------------------------------
    // Gate register
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gates <= '0;
        end else if (bypass) begin
            gates <= BYPASS_PATTERN;
        end else begin
            gates <= pattern_ovl;
        end
    end

endmodule

// ==== verilog/csi_gate_top.sv ====
`timescale 1ns/10ps

module csi_gate_top (
    input  logic                        clk,
    input  logic                        rst,
    input  csi_gate_pkg::hall_code_t    hall,
    input  logic                        enable,
    input  logic                        dir,
    input  logic                        fault_clr,
    output csi_gate_pkg::gate_pattern_t gates,
    output logic                        fault
);
    import csi_gate_pkg::*;

    hall_code_t    hall_accepted;
    logic          hall_invalid;
    logic          enable_sync;
    gate_pattern_t pattern_raw;
    gate_pattern_t pattern_ovl;

    // Sync, deglitch, code check
    hall_input_filter hall_input_filter_inst (
        .clk           (clk),
        .rst           (rst),
        .hall          (hall),
        .enable        (enable),
        .hall_accepted (hall_accepted),
        .hall_invalid  (hall_invalid),
        .enable_sync   (enable_sync)
    );

    commutation_table commutation_table_inst (
        .clk           (clk),
        .rst           (rst),
        .hall_accepted (hall_accepted),
        .hall_invalid  (hall_invalid),
        .dir           (dir),
        .pattern_raw   (pattern_raw)
    );

    // Overlap length from the config default
    commutation_overlap commutation_overlap_inst (
        .clk         (clk),
        .rst         (rst),
        .pattern_raw (pattern_raw),
        .pattern_ovl (pattern_ovl)
    );

    gate_output_stage gate_output_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .pattern_ovl  (pattern_ovl),
        .enable_sync  (enable_sync),
        .hall_invalid (hall_invalid),
        .fault_clr    (fault_clr),
        .gates        (gates),
        .fault        (fault)
    );

endmodule

// ==== sim/csi_gate_checker.sv ====
`timescale 1ns/10ps

module csi_gate_checker #(
    parameter int NAME_CHARS = 24
) (
    input  logic                        clk,
    input  logic                        rst,
    input  csi_gate_pkg::gate_pattern_t gates,
    input  logic                        fault,
    input  logic                        step_start,
    input  logic                        wrap_up,
    input  logic [8*NAME_CHARS-1:0]     step_name,
    input  csi_gate_pkg::gate_pattern_t exp_gates,
    input  logic                        exp_fault,
    input  int                          exp_run_top,
    input  int                          exp_run_bot,
    output int                          step_count,
    output int                          fail_count,
    output logic                        report_done
);
    import csi_gate_pkg::*;

    // Expectations of the step in progress
    logic [8*NAME_CHARS-1:0] want_name;
    gate_pattern_t           want_gates;
    logic                    want_fault;
    int                      want_top;
    int                      want_bot;
    logic                    active;
    // Current and longest runs with two switches of one group on
    int                      run_top;
    int                      run_bot;
    int                      max_top;
    int                      max_bot;
    // Previous fault sample and whether it fell inside the step
    logic                    last_fault;
    logic                    fault_fell;

    // At least two of the three phase bits set
    function automatic logic two_on(input phase_gates_t grp);
        return (grp[0] & grp[1]) | (grp[0] & grp[2]) | (grp[1] & grp[2]);
    endfunction

    // ------------------------------
    // End-of-step compare
    // ------------------------------
    task close_step();
        int errs;
        errs = 0;
        if (gates !== want_gates) begin
            $display("ERR %0s gates expected %b actual %b", want_name, want_gates, gates);
            errs++;
        end
        if (fault !== want_fault) begin
            $display("ERR %0s fault expected %b actual %b", want_name, want_fault, fault);
            errs++;
        end
        // A set fault only clears on a valid code, so it cannot fall and rise again
        if (want_fault && fault_fell) begin
            $display("Step %0s fault fell during the step and had to stay set", want_name);
            errs++;
        end
        if (max_top != want_top) begin
            $display("ERR %0s top overlap expected %0d actual %0d", want_name, want_top, max_top);
            errs++;
        end
        if (max_bot != want_bot) begin
            $display("ERR %0s bot overlap expected %0d actual %0d", want_name, want_bot, max_bot);
            errs++;
        end
        step_count++;
        if (errs == 0) begin
            $display("PASS %0s", want_name);
        end else begin
            $display("FAIL %0s with %0d mismatches", want_name, errs);
            fail_count++;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            active      = 1'b0;
            step_count  = 0;
            fail_count  = 0;
            report_done = 1'b0;
            run_top     = 0;
            run_bot     = 0;
            max_top     = 0;
            max_bot     = 0;
            last_fault  = 1'b0;
            fault_fell  = 1'b0;
        end else begin
            // New step or wrap-up closes the one before
            if (active && (step_start || wrap_up)) begin
                close_step();
            end
            if (step_start) begin
                want_name  = step_name;
                want_gates = exp_gates;
                want_fault = exp_fault;
                want_top   = exp_run_top;
                want_bot   = exp_run_bot;
                run_top    = 0;
                run_bot    = 0;
                max_top    = 0;
                max_bot    = 0;
                last_fault = fault;
                fault_fell = 1'b0;
                active     = 1'b1;
            end else if (active) begin
                run_top = two_on(gates.top) ? run_top + 1 : 0;
                run_bot = two_on(gates.bot) ? run_bot + 1 : 0;
                if (run_top > max_top) begin
                    max_top = run_top;
                end
                if (run_bot > max_bot) begin
                    max_bot = run_bot;
                end
                if (last_fault && !fault) begin
                    fault_fell = 1'b1;
                end
                last_fault = fault;
            end
            if (wrap_up && !report_done) begin
                $display("Checked %0d steps, %0d passed, %0d failed",
                         step_count, step_count - fail_count, fail_count);
                active      = 1'b0;
                report_done = 1'b1;
            end
        end
    end

endmodule

// ==== sim/csi_gate_tb.sv ====
`timescale 1ns/10ps

module csi_gate_tb;
    import csi_gate_pkg::*;

    localparam int NAME_CHARS   = 24;
    localparam int RESET_CYCLES = 16;
    // Cycle within a step where a requested fault_clr pulse goes out
    localparam int CLR_OFFSET   = 25;
    localparam int REPORT_LIMIT = 100;
    localparam int MAX_LINES    = 1000;

    logic          clk;
    logic          rst;
    hall_code_t    hall;
    logic          enable;
    logic          dir;
    logic          fault_clr;
    gate_pattern_t gates;
    logic          fault;

    // Step control and expectations for the checker
    logic                    step_start;
    logic                    wrap_up;
    logic [8*NAME_CHARS-1:0] step_name;
    gate_pattern_t           exp_gates;
    logic                    exp_fault;
    int                      exp_run_top;
    int                      exp_run_bot;
    int                      step_count;
    int                      fail_count;
    logic                    report_done;

    // One parsed row of test data
    logic [8*NAME_CHARS-1:0] row_name;
    hall_code_t              row_hall;
    logic                    row_dir;
    logic                    row_en;
    logic                    row_clr;
    int                      row_hold;
    logic [5:0]              row_gates;
    logic                    row_fault;
    int                      row_run_top;
    int                      row_run_bot;

    logic [8*160-1:0] line_buf;
    int               fd;
    int               got;
    int               fields;
    int               line_no;
    int               rows_applied;
    int               stim_errors;
    logic             setup_failed;
    logic             timed_out;

    always #10 clk = ~clk;

    csi_gate_top csi_gate_top_inst (
        .clk       (clk),
        .rst       (rst),
        .hall      (hall),
        .enable    (enable),
        .dir       (dir),
        .fault_clr (fault_clr),
        .gates     (gates),
        .fault     (fault)
    );

    csi_gate_checker #(
        .NAME_CHARS (NAME_CHARS)
    ) csi_gate_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .gates       (gates),
        .fault       (fault),
        .step_start  (step_start),
        .wrap_up     (wrap_up),
        .step_name   (step_name),
        .exp_gates   (exp_gates),
        .exp_fault   (exp_fault),
        .exp_run_top (exp_run_top),
        .exp_run_bot (exp_run_bot),
        .step_count  (step_count),
        .fail_count  (fail_count),
        .report_done (report_done)
    );

    // ------------------------------
    // Step driver
    // ------------------------------
    // Inputs change 2 ns after the edge, held for row_hold cycles
    task apply_step();
        int i;
        for (i = 0; i < row_hold; i++) begin
            @(posedge clk);
            #2;
            if (i == 0) begin
                hall        = row_hall;
                dir         = row_dir;
                enable      = row_en;
                step_name   = row_name;
                exp_gates   = row_gates;
                exp_fault   = row_fault;
                exp_run_top = row_run_top;
                exp_run_bot = row_run_bot;
            end
            step_start = (i == 0);
            fault_clr  = row_clr && (i == CLR_OFFSET);
        end
        rows_applied++;
    endtask

    // Close the last step and wait for the summary
    task request_report();
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        step_start = 1'b0;
        fault_clr  = 1'b0;
        wrap_up    = 1'b1;
        @(posedge clk);
        #2;
        wrap_up = 1'b0;
        while (!report_done && waited < REPORT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        timed_out = !report_done;
        if (timed_out) begin
            $display("Timeout, checker gave no report within %0d cycles", REPORT_LIMIT);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        hall         = 3'b101;
        enable       = 1'b1;
        dir          = 1'b1;
        fault_clr    = 1'b0;
        step_start   = 1'b0;
        wrap_up      = 1'b0;
        step_name    = '0;
        exp_gates    = '0;
        exp_fault    = 1'b0;
        exp_run_top  = 0;
        exp_run_bot  = 0;
        line_no      = 0;
        rows_applied = 0;
        stim_errors  = 0;
        setup_failed = 1'b0;
        timed_out    = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("sim/csi_gate_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/csi_gate_testdata.txt");
            setup_failed = 1'b1;
        end else begin
            while (!$feof(fd) && line_no < MAX_LINES) begin
                line_buf = '0;
                got = $fgets(line_buf, fd);
                line_no++;
                if (got != 0) begin
                    // Comment rows stop after the first field
                    fields = $sscanf(line_buf, "%s %b %b %b %b %d %b %b %d %d",
                                     row_name, row_hall, row_dir, row_en, row_clr,
                                     row_hold, row_gates, row_fault,
                                     row_run_top, row_run_bot);
                    if (fields == 10) begin
                        apply_step();
                    end else if (fields > 1) begin
                        $display("Test data line %0d is malformed", line_no);
                        stim_errors++;
                    end
                end
            end
            $fclose(fd);
            request_report();
        end

        if (setup_failed || timed_out) begin
            $display("*** TEST FAILED ***");
        end else if (rows_applied == 0 || step_count != rows_applied) begin
            $display("Checker closed %0d steps, %0d applied", step_count, rows_applied);
            $display("*** TEST FAILED ***");
        end else if (fail_count == 0 && stim_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim/csi_gate_testdata.txt ====
# name hall dir enable fault_clr hold gates fault run_top run_bot
# hall, dir, enable, fault_clr, gates (top CBA then bot CBA) and fault in binary, rest decimal
reset_bypass   101 1 1 0 40 001001 1 0 0
fault_clear    101 1 1 1 50 001010 0 0 0
fwd_100        100 1 1 0 40 001100 0 0 10
fwd_110        110 1 1 0 40 010100 0 10 0
fwd_010        010 1 1 0 40 010001 0 0 10
fwd_011        011 1 1 0 40 100001 0 10 0
fwd_001        001 1 1 0 40 100010 0 0 10
fwd_101        101 1 1 0 40 001010 0 10 0
dir_flip       101 0 1 0 40 010001 0 10 10
rev_001        001 0 1 0 40 010100 0 0 10
rev_011        011 0 1 0 40 001100 0 10 0
rev_010        010 0 1 0 40 001010 0 0 10
rev_110        110 0 1 0 40 100010 0 10 0
rev_100        100 0 1 0 40 100001 0 0 10
rev_101        101 0 1 0 40 010001 0 10 0
back_fwd       101 1 1 0 40 001010 0 10 10
glitch_pulse   100 1 1 0 2  001010 0 0 0
glitch_settle  101 1 1 0 40 001010 0 0 0
invalid_000    000 1 1 0 40 001001 1 0 0
clr_while_bad  000 1 1 1 50 001001 1 0 0
valid_no_clr   101 1 1 0 40 001001 1 0 0
clr_restore    101 1 1 1 50 001010 0 0 0
invalid_111    111 1 1 0 40 001001 1 0 0
recover_100    100 1 1 1 50 001100 0 0 0
enable_low     100 1 0 0 40 001001 0 0 0
hall_while_off 110 1 0 0 40 001001 0 0 0
enable_high    110 1 1 0 40 010100 0 0 0

// ==== list.f ====
+incdir+verilog
verilog/csi_gate_pkg.sv
verilog/hall_input_filter.sv
verilog/commutation_table.sv
verilog/commutation_overlap.sv
verilog/gate_output_stage.sv
verilog/csi_gate_top.sv
sim/csi_gate_checker.sv
sim/csi_gate_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSI gate testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

LOG=sim_run.log

verilator --binary --timing --timescale 1ns/10ps -f list.f --top-module csi_gate_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcsi_gate_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF -- '*** TEST PASSED ***' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
